// File: verilog/cacheGeometryPkg.sv
/*
 Geometry of the direct-mapped L1 data cache.
 Widths and vector types for addresses, line tags, indices and line data,
 shared by the cache modules and the testbench.
*/

package cacheGeometryPkg;

	localparam int addrWidth = 32;
	localparam int indexWidth = 6;
	localparam int lineBytes = 16;

	// derived from the ones above
	localparam int offsetWidth = $clog2(lineBytes);
	localparam int tagWidth = addrWidth - indexWidth - offsetWidth;
	localparam int lineCount = 1 << indexWidth;
	localparam int wordWidth = 64;

	typedef logic [addrWidth-1:0] addrT;
	typedef logic [indexWidth-1:0] lineIndexT;
	typedef logic [tagWidth-1:0] lineTagT;
	typedef logic [lineBytes*8-1:0] lineDataT;
	typedef logic [wordWidth-1:0] wordT;

	// top nibble of a flush address that selects every line
	localparam logic [3:0] flushAllNibble = 4'hF;

endpackage

// File: verilog/memBusPkg.sv
/*
 Operation and status codes of the load/store port and the memory bus.
 An opm has the store flag in bit 4, the load flag in bit 3, and the
 access size with the unsigned flag in bits 2..0.
*/

package memBusPkg;

	typedef logic [4:0] opmT;
	typedef logic [1:0] okT;

	// fields of an opm
	localparam int opmStoreBit = 4;
	localparam int opmLoadBit = 3;
	localparam int opmUnsignedBit = 2;

	localparam opmT opmReady = 5'b00000;
	localparam opmT opmFlush = 5'b00010;

	// whole-line transfers on the memory bus
	localparam opmT opmRdTile = 5'b01111;
	localparam opmT opmWrTile = 5'b10111;

	// status levels, code 2'b11 is not used
	localparam okT okReady = 2'b00;
	localparam okT okOk = 2'b01;
	localparam okT okHold = 2'b10;

endpackage

// File: verilog/cacheLinkIf.sv
/*
 Links between the cache blocks.
 lineWriteIf carries one line write into the line store.
 missIf hands a miss from the lookup to the miss handler.
*/

`timescale 1ns/1ps

interface lineWriteIf;

	logic enable;
	cacheGeometryPkg::lineIndexT index;
	cacheGeometryPkg::lineTagT tag;
	logic dirty;
	cacheGeometryPkg::lineDataT data;

	modport writer (output enable, index, tag, dirty, data);
	modport store (input enable, index, tag, dirty, data);

endinterface

interface missIf;

	logic miss;
	// request address without the byte offset, tag above index
	logic [cacheGeometryPkg::tagWidth+cacheGeometryPkg::indexWidth-1:0] reqLine;
	cacheGeometryPkg::lineTagT victimTag;
	logic victimDirty;
	cacheGeometryPkg::lineDataT victimData;
	logic busy;

	modport lookup (output miss, reqLine, victimTag, victimDirty, victimData,
		input busy);
	modport handler (input miss, reqLine, victimTag, victimDirty, victimData,
		output busy);

endinterface

// File: verilog/cacheLineStore.sv
/*
 Line storage of the data cache: data, tag and dirty state per index,
 one registered read port and two write ports (store and fill).
 The flush mask marks lines that must miss; their dirty data is kept.
*/

`timescale 1ns/1ps

module cacheLineStore (
	input logic clock,
	input logic reset,
	input cacheGeometryPkg::lineIndexT readIndex,
	output cacheGeometryPkg::lineTagT readTag,
	output logic readDirty,
	output logic readValid,
	output cacheGeometryPkg::lineDataT readData,
	input logic flushOne,
	input logic flushAll,
	input cacheGeometryPkg::lineIndexT flushIndex,
	lineWriteIf.store storeWrite,
	lineWriteIf.store fillWrite
);

	cacheGeometryPkg::lineDataT dataMem [cacheGeometryPkg::lineCount];
	cacheGeometryPkg::lineTagT tagMem [cacheGeometryPkg::lineCount];
	logic [cacheGeometryPkg::lineCount-1:0] dirtyMask;
	logic [cacheGeometryPkg::lineCount-1:0] flushMask;
	logic [cacheGeometryPkg::lineCount-1:0] nextFlushMask;

	// a fill revalidates its line
	always_comb
	begin
		nextFlushMask = flushMask;
		if (fillWrite.enable)
			nextFlushMask[fillWrite.index] = 1'b0;
		if (flushOne)
			nextFlushMask[flushIndex] = 1'b1;
		if (flushAll)
			nextFlushMask = '1;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			flushMask <= '1;
			dirtyMask <= '0;
		end
		else
		begin
			flushMask <= nextFlushMask;
			if (storeWrite.enable)
				dirtyMask[storeWrite.index] <= storeWrite.dirty;
			if (fillWrite.enable)
				dirtyMask[fillWrite.index] <= fillWrite.dirty;
		end
	end

	always_ff @(posedge clock)
	begin
		readData <= dataMem[readIndex];
		readTag <= tagMem[readIndex];
		readDirty <= dirtyMask[readIndex];
		// flush of this edge already counts for the read
		readValid <= !nextFlushMask[readIndex];
		if (storeWrite.enable)
		begin
			dataMem[storeWrite.index] <= storeWrite.data;
			tagMem[storeWrite.index] <= storeWrite.tag;
		end
		if (fillWrite.enable)
		begin
			dataMem[fillWrite.index] <= fillWrite.data;
			tagMem[fillWrite.index] <= fillWrite.tag;
		end
	end

endmodule

// File: verilog/cacheLookup.sv
/*
 Request side of the data cache.
 Registers a load, store or flush, tests the line read back for a hit,
 returns extended load data, merges store data into the line, and holds
 the pipeline on a miss until the miss handler has refilled the line.
*/

`timescale 1ns/1ps

module cacheLookup (
	input logic clock,
	input logic reset,
	input cacheGeometryPkg::addrT regInAddr,
	input memBusPkg::opmT regInOpm,
	input cacheGeometryPkg::wordT regInVal,
	output cacheGeometryPkg::wordT regOutVal,
	output memBusPkg::okT regOutOk,
	output cacheGeometryPkg::lineIndexT readIndex,
	input cacheGeometryPkg::lineTagT readTag,
	input logic readDirty,
	input logic readValid,
	input cacheGeometryPkg::lineDataT readData,
	output logic flushOne,
	output logic flushAll,
	output cacheGeometryPkg::lineIndexT flushIndex,
	lineWriteIf.writer storeWrite,
	missIf.lookup miss
);

	cacheGeometryPkg::addrT reqAddr;
	memBusPkg::opmT reqOpm;
	cacheGeometryPkg::wordT reqVal;
	cacheGeometryPkg::lineIndexT reqIndex;
	cacheGeometryPkg::lineTagT reqTag;
	logic [cacheGeometryPkg::offsetWidth-1:0] reqOffset;
	logic isLoad, isStore, isAccess, isFlush;
	logic hit, lineHold, storeHit, storeHold, hold;
	logic storeDone;
	cacheGeometryPkg::lineDataT lineShift;
	cacheGeometryPkg::lineDataT storeLine;
	cacheGeometryPkg::lineDataT mergedLine;
	cacheGeometryPkg::wordT rawVal;
	logic signedLoad;
	logic [cacheGeometryPkg::lineBytes-1:0] sizeMask;
	logic [cacheGeometryPkg::lineBytes-1:0] byteMask;

	assign reqIndex = reqAddr[cacheGeometryPkg::offsetWidth +: cacheGeometryPkg::indexWidth];
	assign reqTag = reqAddr[cacheGeometryPkg::addrWidth-1 -: cacheGeometryPkg::tagWidth];
	assign reqOffset = reqAddr[cacheGeometryPkg::offsetWidth-1:0];

	assign isLoad = reqOpm[memBusPkg::opmLoadBit];
	assign isStore = reqOpm[memBusPkg::opmStoreBit];
	assign isAccess = isLoad || isStore;
	assign isFlush = (reqOpm == memBusPkg::opmFlush);

	assign hit = readValid && (readTag == reqTag);
	// busy covers the cycles after the fill until the line is read back
	assign lineHold = isAccess && (!hit || miss.busy);
	assign storeHit = isStore && hit && !miss.busy;
	assign storeHold = storeHit && !storeDone;
	assign hold = lineHold || storeHold;

	assign regOutOk = hold ? memBusPkg::okHold :
		((reqOpm == memBusPkg::opmReady) ? memBusPkg::okReady : memBusPkg::okOk);

	// keep reading the held line so a refill shows up
	assign readIndex = hold ? reqIndex :
		regInAddr[cacheGeometryPkg::offsetWidth +: cacheGeometryPkg::indexWidth];

	assign flushOne = isFlush &&
		(reqAddr[cacheGeometryPkg::addrWidth-1 -: 4] != cacheGeometryPkg::flushAllNibble);
	assign flushAll = isFlush &&
		(reqAddr[cacheGeometryPkg::addrWidth-1 -: 4] == cacheGeometryPkg::flushAllNibble);
	assign flushIndex = reqIndex;

	assign miss.miss = isAccess && !hit;
	assign miss.reqLine = reqAddr[cacheGeometryPkg::addrWidth-1:cacheGeometryPkg::offsetWidth];
	assign miss.victimTag = readTag;
	assign miss.victimDirty = readDirty;
	assign miss.victimData = readData;

	// load extraction, size in opm bits 1..0
	always_comb
	begin
		lineShift = readData >> {reqOffset, 3'b000};
		rawVal = lineShift[63:0];
		signedLoad = !reqOpm[memBusPkg::opmUnsignedBit];
		case (reqOpm[1:0])
			2'b00: regOutVal = {{56{signedLoad && rawVal[7]}}, rawVal[7:0]};
			2'b01: regOutVal = {{48{signedLoad && rawVal[15]}}, rawVal[15:0]};
			2'b10: regOutVal = {{32{signedLoad && rawVal[31]}}, rawVal[31:0]};
			default: regOutVal = rawVal;
		endcase
	end

	// store merge into the line as read
	always_comb
	begin
		case (reqOpm[1:0])
			2'b00: sizeMask = 16'h0001;
			2'b01: sizeMask = 16'h0003;
			2'b10: sizeMask = 16'h000F;
			default: sizeMask = 16'h00FF;
		endcase
		byteMask = sizeMask << reqOffset;
		storeLine = cacheGeometryPkg::lineDataT'(reqVal) << {reqOffset, 3'b000};
		mergedLine = readData;
		for (int i = 0; i < cacheGeometryPkg::lineBytes; i++)
		begin
			if (byteMask[i])
				mergedLine[i*8 +: 8] = storeLine[i*8 +: 8];
		end
	end

	// written during the store's hold cycle
	assign storeWrite.enable = storeHold;
	assign storeWrite.index = reqIndex;
	assign storeWrite.tag = reqTag;
	assign storeWrite.dirty = 1'b1;
	assign storeWrite.data = mergedLine;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			reqOpm <= memBusPkg::opmReady;
			storeDone <= 1'b0;
		end
		else
		begin
			if (!hold)
				reqOpm <= regInOpm;
			storeDone <= storeHold;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			reqAddr <= regInAddr;
			reqVal <= regInVal;
		end
	end

endmodule

// File: verilog/missHandler.sv
/*
 Miss handler of the data cache.
 On a miss it writes a dirty victim back, then reads the requested line
 over the memory bus and writes it into the line store clean.
 Bus levels: opm out on READY, held through HOLD, dropped on OK.
*/

`timescale 1ns/1ps

module missHandler (
	input logic clock,
	input logic reset,
	output cacheGeometryPkg::addrT memAddr,
	output memBusPkg::opmT memOpm,
	output cacheGeometryPkg::lineDataT memDataOut,
	input cacheGeometryPkg::lineDataT memDataIn,
	input memBusPkg::okT memOk,
	missIf.handler miss,
	lineWriteIf.writer fillWrite
);

	typedef enum logic [2:0] {
		stIdle,
		stWriteBack,
		stWriteBackWait,
		stFill,
		stFillWait
	} stateT;

	stateT state;
	cacheGeometryPkg::lineIndexT reqIndex;
	cacheGeometryPkg::lineTagT reqTag;
	logic fillDone;

	assign reqIndex = miss.reqLine[cacheGeometryPkg::indexWidth-1:0];
	assign reqTag = miss.reqLine[cacheGeometryPkg::tagWidth+cacheGeometryPkg::indexWidth-1 -:
		cacheGeometryPkg::tagWidth];

	// read data arrives with OK while the tile read is still out
	assign fillDone = (state == stFillWait) && (memOpm == memBusPkg::opmRdTile) &&
		(memOk == memBusPkg::okOk);

	assign fillWrite.enable = fillDone;
	assign fillWrite.index = reqIndex;
	assign fillWrite.tag = reqTag;
	assign fillWrite.dirty = 1'b0;
	assign fillWrite.data = memDataIn;

	assign miss.busy = (state != stIdle);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= stIdle;
			memOpm <= memBusPkg::opmReady;
		end
		else
		begin
			case (state)
				stIdle:
					if (miss.miss)
						state <= miss.victimDirty ? stWriteBack : stFill;
				stWriteBack:
					if (memOk == memBusPkg::okReady)
					begin
						memOpm <= memBusPkg::opmWrTile;
						state <= stWriteBackWait;
					end
				stWriteBackWait:
					if (memOk == memBusPkg::okOk)
					begin
						memOpm <= memBusPkg::opmReady;
						state <= stFill;
					end
				// also waits out the READY after the write-back
				stFill:
					if (memOk == memBusPkg::okReady)
					begin
						memOpm <= memBusPkg::opmRdTile;
						state <= stFillWait;
					end
				stFillWait:
					if (fillDone)
						memOpm <= memBusPkg::opmReady;
					else if ((memOpm == memBusPkg::opmReady) &&
						(memOk == memBusPkg::okReady))
						state <= stIdle;
				default:
					state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if ((state == stWriteBack) && (memOk == memBusPkg::okReady))
		begin
			// victim goes back to its own line address
			memAddr <= {miss.victimTag, reqIndex, {cacheGeometryPkg::offsetWidth{1'b0}}};
			memDataOut <= miss.victimData;
		end
		else if ((state == stFill) && (memOk == memBusPkg::okReady))
			memAddr <= {miss.reqLine, {cacheGeometryPkg::offsetWidth{1'b0}}};
	end

endmodule

// File: verilog/dataCacheTop.sv
/*
 Direct-mapped write-back L1 data cache, 64 lines of 16 bytes.
 Load/store port on the regIn/regOut signals, tile memory bus on mem*.
*/

`timescale 1ns/1ps

module dataCacheTop (
	input logic clock,
	input logic reset,
	input cacheGeometryPkg::addrT regInAddr,
	input memBusPkg::opmT regInOpm,
	input cacheGeometryPkg::wordT regInVal,
	output cacheGeometryPkg::wordT regOutVal,
	output memBusPkg::okT regOutOk,
	output cacheGeometryPkg::addrT memAddr,
	output memBusPkg::opmT memOpm,
	output cacheGeometryPkg::lineDataT memDataOut,
	input cacheGeometryPkg::lineDataT memDataIn,
	input memBusPkg::okT memOk
);

	cacheGeometryPkg::lineIndexT readIndex;
	cacheGeometryPkg::lineTagT readTag;
	logic readDirty;
	logic readValid;
	cacheGeometryPkg::lineDataT readData;
	logic flushOne;
	logic flushAll;
	cacheGeometryPkg::lineIndexT flushIndex;

	lineWriteIf storeWrite ();
	lineWriteIf fillWrite ();
	missIf miss ();

	cacheLineStore lineStore (
		.clock(clock), .reset(reset),
		.readIndex(readIndex), .readTag(readTag), .readDirty(readDirty),
		.readValid(readValid), .readData(readData),
		.flushOne(flushOne), .flushAll(flushAll), .flushIndex(flushIndex),
		.storeWrite(storeWrite.store), .fillWrite(fillWrite.store)
	);

	cacheLookup lookup (
		.clock(clock), .reset(reset),
		.regInAddr(regInAddr), .regInOpm(regInOpm), .regInVal(regInVal),
		.regOutVal(regOutVal), .regOutOk(regOutOk),
		.readIndex(readIndex), .readTag(readTag), .readDirty(readDirty),
		.readValid(readValid), .readData(readData),
		.flushOne(flushOne), .flushAll(flushAll), .flushIndex(flushIndex),
		.storeWrite(storeWrite.writer), .miss(miss.lookup)
	);

	missHandler handler (
		.clock(clock), .reset(reset),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.memDataIn(memDataIn), .memOk(memOk),
		.miss(miss.handler), .fillWrite(fillWrite.writer)
	);

endmodule

// File: verif/dataCacheChecker.sv
/*
 Protocol assertions for the data cache, bound into dataCacheTop.
 Watches the tile memory bus and the load/store status levels.
 assertFails counts failures so the testbench can see them at the end.
*/

`timescale 1ns/1ps

module dataCacheChecker (
	input logic clock,
	input logic reset,
	input memBusPkg::okT regOutOk,
	input memBusPkg::opmT memOpm,
	input cacheGeometryPkg::addrT memAddr,
	input memBusPkg::okT memOk
);

	int assertFails = 0;

	// a pending transfer stays put while memory holds
	busHeld: assert property (@(posedge clock) disable iff (reset)
		(memOpm != memBusPkg::opmReady && memOk == memBusPkg::okHold)
		|=> ($stable(memOpm) && $stable(memAddr)))
	else
	begin
		$error("memory bus request changed while memory held it");
		assertFails++;
	end

	// code 2'b11 is never a status
	statusCode: assert property (@(posedge clock) disable iff (reset)
		regOutOk != 2'b11)
	else
	begin
		$error("regOutOk showed the unused status code");
		assertFails++;
	end

	busIdleAfterReset: assert property (@(posedge clock)
		$fell(reset) |-> (memOpm == memBusPkg::opmReady))
	else
	begin
		$error("memory bus was not idle right after reset");
		assertFails++;
	end

endmodule

bind dataCacheTop dataCacheChecker protocolCheck (
	.clock(clock),
	.reset(reset),
	.regOutOk(regOutOk),
	.memOpm(memOpm),
	.memAddr(memAddr),
	.memOk(memOk)
);

// File: verif/dataCacheTb.sv
/*
 Testbench of the direct-mapped L1 data cache.
 Runs a table of loads, stores and flushes through the load/store port,
 answers the tile bus from a memory model with random latency, and
 predicts every load and every write-back from a byte mirror.
*/

`timescale 1ns/1ps

module dataCacheTb;

	typedef struct {
		string name;
		memBusPkg::opmT opm;
		cacheGeometryPkg::addrT addr;
		cacheGeometryPkg::wordT val;
		memBusPkg::opmT firstBusOp;
	} stepT;

	logic clock;
	logic reset;
	cacheGeometryPkg::addrT regInAddr;
	memBusPkg::opmT regInOpm;
	cacheGeometryPkg::wordT regInVal;
	cacheGeometryPkg::wordT regOutVal;
	memBusPkg::okT regOutOk;
	cacheGeometryPkg::addrT memAddr;
	memBusPkg::opmT memOpm;
	cacheGeometryPkg::lineDataT memDataOut;
	cacheGeometryPkg::lineDataT memDataIn;
	memBusPkg::okT memOk;

	stepT steps [$];
	// bus operations started during the current step
	memBusPkg::opmT busLog [$];
	logic [7:0] mirrorMem [cacheGeometryPkg::addrT];
	cacheGeometryPkg::lineDataT memLines [cacheGeometryPkg::addrT];
	string curName = "reset";
	int cycleCount = 0;
	int cycleLimit = 0;

	dataCacheTop dut (
		.clock(clock), .reset(reset),
		.regInAddr(regInAddr), .regInOpm(regInOpm), .regInVal(regInVal),
		.regOutVal(regOutVal), .regOutOk(regOutOk),
		.memAddr(memAddr), .memOpm(memOpm), .memDataOut(memDataOut),
		.memDataIn(memDataIn), .memOk(memOk)
	);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic compareWord(input string name, input cacheGeometryPkg::wordT expected,
		input cacheGeometryPkg::wordT actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected %h actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "load value mismatch");
		end
	endtask

	task automatic checkStatus(input string name, input memBusPkg::okT expected,
		input memBusPkg::okT actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected %h actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "status mismatch");
		end
	endtask

	task automatic verifyLine(input string name, input cacheGeometryPkg::lineDataT expected,
		input cacheGeometryPkg::lineDataT actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected %h actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "line data mismatch");
		end
	endtask

	task automatic expectBusOp(input string name, input memBusPkg::opmT expected,
		input memBusPkg::opmT actual);
		if (actual !== expected)
		begin
			$display("** Error: %s expected %h actual %h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1, "bus operation mismatch");
		end
	endtask

	// untouched memory: each 32-bit word is its address XOR A5A5_0000
	function automatic logic [7:0] defaultByte(input cacheGeometryPkg::addrT a);
		logic [31:0] word;
		word = {a[31:2], 2'b00} ^ 32'hA5A5_0000;
		return word[a[1:0]*8 +: 8];
	endfunction

	function automatic logic [7:0] mirrorByte(input cacheGeometryPkg::addrT a);
		if (mirrorMem.exists(a))
			return mirrorMem[a];
		return defaultByte(a);
	endfunction

	function automatic cacheGeometryPkg::lineDataT mirrorLine(input cacheGeometryPkg::addrT base);
		cacheGeometryPkg::lineDataT line;
		for (int i = 0; i < cacheGeometryPkg::lineBytes; i++)
			line[i*8 +: 8] = mirrorByte(base + i);
		return line;
	endfunction

	function automatic cacheGeometryPkg::lineDataT memLine(input cacheGeometryPkg::addrT base);
		cacheGeometryPkg::lineDataT line;
		if (memLines.exists(base))
			return memLines[base];
		for (int i = 0; i < cacheGeometryPkg::lineBytes; i++)
			line[i*8 +: 8] = defaultByte(base + i);
		return line;
	endfunction

	// size is 1 << opm[1:0] bytes, little endian
	function automatic cacheGeometryPkg::wordT predictLoad(input memBusPkg::opmT opm,
		input cacheGeometryPkg::addrT a);
		cacheGeometryPkg::wordT value;
		int size;
		logic fill;
		size = 1 << opm[1:0];
		value = '0;
		for (int i = 0; i < size; i++)
			value[i*8 +: 8] = mirrorByte(a + i);
		fill = !opm[memBusPkg::opmUnsignedBit] && value[size*8-1];
		for (int i = size; i < 8; i++)
			value[i*8 +: 8] = {8{fill}};
		return value;
	endfunction

	task automatic applyStore(input memBusPkg::opmT opm, input cacheGeometryPkg::addrT a,
		input cacheGeometryPkg::wordT val);
		int size;
		size = 1 << opm[1:0];
		for (int i = 0; i < size; i++)
			mirrorMem[a + i] = val[i*8 +: 8];
	endtask

	// memory model on the tile bus
	initial
	begin
		memBusPkg::opmT opm;
		cacheGeometryPkg::addrT addr;
		int latency;
		void'($urandom(32'h5f85));
		memOk = memBusPkg::okReady;
		memDataIn = '0;
		forever
		begin
			@(posedge clock);
			#1;
			if (!reset && memOpm != memBusPkg::opmReady && memOk == memBusPkg::okReady)
			begin
				opm = memOpm;
				addr = memAddr;
				busLog.push_back(opm);
				latency = 1 + int'($urandom % 3);
				memOk = memBusPkg::okHold;
				repeat (latency)
				begin
					@(posedge clock);
					#1;
				end
				if (opm == memBusPkg::opmWrTile)
				begin
					// a victim must carry every store made to it
					verifyLine({curName, " write-back"}, mirrorLine(addr), memDataOut);
					memLines[addr] = memDataOut;
				end
				else
					memDataIn = memLine(addr);
				memOk = memBusPkg::okOk;
				do
				begin
					@(posedge clock);
					#1;
				end
				while (memOpm != memBusPkg::opmReady);
				memOk = memBusPkg::okReady;
			end
		end
	end

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("CHECKS FAILED");
			$fatal(1, "timeout, run did not finish within %0d cycles", cycleLimit);
		end
	end

	task automatic addStep(input string name, input memBusPkg::opmT opm,
		input cacheGeometryPkg::addrT addr, input cacheGeometryPkg::wordT val,
		input memBusPkg::opmT firstBusOp);
		stepT s;
		s.name = name;
		s.opm = opm;
		s.addr = addr;
		s.val = val;
		s.firstBusOp = firstBusOp;
		steps.push_back(s);
	endtask

	// columns: name, opm, address, store data, first bus operation
	task automatic buildTable();
		addStep("idle", memBusPkg::opmReady, 32'h0, '0, memBusPkg::opmReady);
		addStep("lb miss", 5'b01000, 32'h0000_0107, '0, memBusPkg::opmRdTile);
		addStep("lbu hit", 5'b01100, 32'h0000_0103, '0, memBusPkg::opmReady);
		addStep("lw hit", 5'b01001, 32'h0000_0102, '0, memBusPkg::opmReady);
		addStep("lwu hit", 5'b01101, 32'h0000_010C, '0, memBusPkg::opmReady);
		addStep("ld hit", 5'b01010, 32'h0000_0108, '0, memBusPkg::opmReady);
		addStep("ldu hit", 5'b01110, 32'h0000_0104, '0, memBusPkg::opmReady);
		addStep("lq hit", 5'b01011, 32'h0000_0108, '0, memBusPkg::opmReady);
		addStep("lw miss", 5'b01001, 32'h0000_0222, '0, memBusPkg::opmRdTile);
		addStep("ldu miss", 5'b01110, 32'h0000_0334, '0, memBusPkg::opmRdTile);
		addStep("lq miss", 5'b01011, 32'h0000_0448, '0, memBusPkg::opmRdTile);
		addStep("lbu miss", 5'b01100, 32'h0000_0551, '0, memBusPkg::opmRdTile);
		addStep("sb hit", 5'b10000, 32'h0000_0101, 64'h80, memBusPkg::opmReady);
		addStep("sw hit", 5'b10001, 32'h0000_0104, 64'hBEEF, memBusPkg::opmReady);
		addStep("sd hit", 5'b10010, 32'h0000_0108, 64'h8765_4321, memBusPkg::opmReady);
		addStep("sq hit", 5'b10011, 32'h0000_0108, 64'hFEDC_BA98_7654_3210,
			memBusPkg::opmReady);
		addStep("lq merged", 5'b01011, 32'h0000_0100, '0, memBusPkg::opmReady);
		addStep("lb merged", 5'b01000, 32'h0000_0101, '0, memBusPkg::opmReady);
		addStep("ldu merged", 5'b01110, 32'h0000_0104, '0, memBusPkg::opmReady);
		addStep("sb miss", 5'b10000, 32'h0000_0667, 64'h5A, memBusPkg::opmRdTile);
		addStep("lbu stored", 5'b01100, 32'h0000_0667, '0, memBusPkg::opmReady);
		addStep("lw evict", 5'b01001, 32'h0000_0500, '0, memBusPkg::opmWrTile);
		addStep("lq back", 5'b01011, 32'h0000_0108, '0, memBusPkg::opmRdTile);
		addStep("sd dirty", 5'b10010, 32'h0000_0224, 64'h1357_9BDF, memBusPkg::opmReady);
		addStep("flush one", memBusPkg::opmFlush, 32'h0000_0220, '0, memBusPkg::opmReady);
		addStep("ld flushed", 5'b01010, 32'h0000_0224, '0, memBusPkg::opmWrTile);
		addStep("lw clean", 5'b01001, 32'h0000_0332, '0, memBusPkg::opmReady);
		addStep("flush all", memBusPkg::opmFlush, 32'hF000_0000, '0, memBusPkg::opmReady);
		addStep("lw after all", 5'b01001, 32'h0000_0332, '0, memBusPkg::opmRdTile);
		addStep("lb after all", 5'b01000, 32'h0000_0101, '0, memBusPkg::opmRdTile);
		addStep("sb flushed", 5'b10000, 32'h0000_0448, 64'hC3, memBusPkg::opmRdTile);
		addStep("lb evict", 5'b01000, 32'h0000_0048, '0, memBusPkg::opmWrTile);
		addStep("lbu dirty flushed", 5'b01100, 32'h0000_0660, '0, memBusPkg::opmWrTile);
		addStep("idle end", memBusPkg::opmReady, 32'h0, '0, memBusPkg::opmReady);
	endtask

	// entered one delay after an edge, returns at the same point
	task automatic runStep(input stepT s);
		cacheGeometryPkg::wordT expVal;
		memBusPkg::okT expFirst;
		memBusPkg::okT expFinal;
		memBusPkg::opmT busOp;
		logic isStore;
		logic isLoad;
		isStore = s.opm[memBusPkg::opmStoreBit];
		isLoad = s.opm[memBusPkg::opmLoadBit];
		expVal = predictLoad(s.opm, s.addr);
		// stores and misses hold first
		if (s.opm == memBusPkg::opmReady)
			expFirst = memBusPkg::okReady;
		else if (isStore || s.firstBusOp != memBusPkg::opmReady)
			expFirst = memBusPkg::okHold;
		else
			expFirst = memBusPkg::okOk;
		expFinal = (s.opm == memBusPkg::opmReady) ? memBusPkg::okReady : memBusPkg::okOk;
		curName = s.name;
		busLog.delete();
		regInOpm = s.opm;
		regInAddr = s.addr;
		regInVal = s.val;
		@(posedge clock);
		#1;
		checkStatus({s.name, " first status"}, expFirst, regOutOk);
		while (regOutOk == memBusPkg::okHold)
		begin
			@(posedge clock);
			#1;
		end
		checkStatus(s.name, expFinal, regOutOk);
		if (isLoad)
			compareWord(s.name, expVal, regOutVal);
		busOp = (busLog.size() > 0) ? busLog[0] : memBusPkg::opmReady;
		expectBusOp({s.name, " bus"}, s.firstBusOp, busOp);
		if (isStore)
			applyStore(s.opm, s.addr, s.val);
	endtask

	initial
	begin
		reset = 1'b1;
		regInAddr = '0;
		regInOpm = memBusPkg::opmReady;
		regInVal = '0;
		buildTable();
		cycleLimit = steps.size() * 40 + 200;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		checkStatus("reset", memBusPkg::okReady, regOutOk);
		expectBusOp("reset", memBusPkg::opmReady, memOpm);
		foreach (steps[i])
			runStep(steps[i]);
		repeat (4) @(posedge clock);
		if (dut.protocolCheck.assertFails == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
		begin
			$display("CHECKS FAILED");
			$fatal(1, "%0d protocol assertions failed", dut.protocolCheck.assertFails);
		end
	end

endmodule

// File: all.f
verilog/cacheGeometryPkg.sv
verilog/memBusPkg.sv
verilog/cacheLinkIf.sv
verilog/cacheLineStore.sv
verilog/cacheLookup.sv
verilog/missHandler.sv
verilog/dataCacheTop.sv
verif/dataCacheChecker.sv
verif/dataCacheTb.sv

// File: run.sh
#!/bin/sh
# Builds the data cache testbench with Verilator and runs it.
# The exit status is that of the failing step, or 0 when the run passes.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module dataCacheTb -Mdir obj_dir -f all.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/VdataCacheTb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
